// ==== rtl/sap_pkg.sv ====
`default_nettype none

package sap_pkg;

    localparam int data_w    = 8;   // Word width of the whole machine
    localparam int addr_w    = 4;   // Memory and PC address width
    localparam int mem_depth = 16;  // Bytes of program and data memory

    // Instruction byte is {opcode, operand}
    typedef enum logic [3:0] {
        NOP = 4'd0,
        LDA = 4'd1,
        ADD = 4'd2,
        SUB = 4'd3,
        STA = 4'd4,
        LDI = 4'd5,
        JMP = 4'd6,
        JC  = 4'd7,
        JZ  = 4'd8,
        OUT = 4'd14,
        HLT = 4'd15
    } opcode_e;

    // Sequencer steps, fetch in T0 and T1
    typedef enum logic [2:0] {
        T0,
        T1,
        T2,
        T3,
        T4,
        HALT
    } step_e;

    // Driver of the internal bus
    typedef enum logic [2:0] {
        BUS_NONE,   // Bus reads zero
        BUS_PC,
        BUS_RAM,
        BUS_IR,     // Operand nibble only
        BUS_A,
        BUS_ALU
    } bus_src_e;

    // One control word per cycle, all lines active high
    typedef struct packed {
        bus_src_e bus_src;
        logic     pc_inc;
        logic     pc_load;
        logic     mar_load;
        logic     ram_write;
        logic     ir_load;
        logic     a_load;
        logic     b_load;
        logic     alu_sub;
        logic     flag_load;  // Update carry and zero
        logic     out_load;
    } ctrl_word_t;

    typedef struct packed {
        logic carry;
        logic zero;
    } alu_flags_t;

    // Memory write request
    typedef struct packed {
        logic              en;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } mem_wr_t;

endpackage

`default_nettype wire

// ==== rtl/sap_programmer.sv ====
`default_nettype none

module sap_programmer (
    input  logic             clk,
    input  logic             rst,
    input  logic             prog_mode,
    input  logic [7:0]       prog_data,
    input  logic             prog_valid,
    output logic             prog_ready,
    output sap_pkg::mem_wr_t loader_wr,
    output logic             core_hold
);
    import sap_pkg::*;

    logic              mode_q;     // prog_mode one cycle late
    logic              entry;      // First cycle of a programming window
    logic              accept;     // Handshake taken this cycle
    logic [addr_w-1:0] load_addr;  // Next byte goes here

    assign entry  = prog_mode & ~mode_q;
    // Gated by prog_mode so a late byte never lands while the core runs
    assign accept = prog_valid & prog_ready & prog_mode;

    always_ff @(posedge clk) begin
        if (rst) begin
            mode_q     <= 1'b0;
            prog_ready <= 1'b0;
        end else begin
            mode_q     <= prog_mode;
            prog_ready <= prog_mode;  // High the cycle after mode is seen
        end
    end

    // Address counter, wraps after 16 bytes
    always_ff @(posedge clk) begin
        if (rst || entry) begin
            load_addr <= '0;  // Every window starts at byte 0
        end else if (accept) begin
            load_addr <= load_addr + 1'b1;
        end
    end

    // Byte goes to memory in the same cycle it is accepted
    always_comb begin
        loader_wr.en   = accept;
        loader_wr.addr = load_addr;
        loader_wr.data = prog_data;
    end

    // Core stays in restart for the whole window
    assign core_hold = prog_mode;

endmodule

`default_nettype wire

// ==== rtl/sap_control.sv ====
`default_nettype none

module sap_control (
    input  logic                clk,
    input  logic                rst,
    input  logic                core_hold,
    input  sap_pkg::opcode_e    opcode,
    input  sap_pkg::alu_flags_t flags,
    input  logic                out_pending,  // Output byte not yet taken
    output sap_pkg::ctrl_word_t ctrl,
    output logic                halted
);
    import sap_pkg::*;

    step_e step_q;
    step_e step_d;

    always_ff @(posedge clk) begin
        if (rst || core_hold) begin
            step_q <= T0;
        end else begin
            step_q <= step_d;
        end
    end

    // Step sequence
    always_comb begin
        step_d = step_q;
        case (step_q)
            T0: step_d = T1;
            T1: step_d = T2;
            T2: begin
                if (opcode == HLT) begin
                    step_d = HALT;
                end else if (opcode == OUT && out_pending) begin
                    step_d = T2;  // Stall until the pending byte is taken
                end else begin
                    step_d = T3;
                end
            end
            T3:      step_d = T4;
            T4:      step_d = T0;
            HALT:    step_d = HALT;  // Only rst or hold leaves
            default: step_d = T0;
        endcase
    end

    // Control word decode
    always_comb begin
        ctrl = '0;  // Idle unless a step says otherwise
        if (!core_hold) begin
            case (step_q)
                T0: begin
                    ctrl.bus_src  = BUS_PC;   // Fetch address
                    ctrl.mar_load = 1'b1;
                end
                T1: begin
                    ctrl.bus_src = BUS_RAM;   // Instruction byte
                    ctrl.ir_load = 1'b1;
                    ctrl.pc_inc  = 1'b1;
                end
                T2: begin
                    case (opcode)
                        LDA, ADD, SUB, STA: begin
                            ctrl.bus_src  = BUS_IR;  // Operand is the data address
                            ctrl.mar_load = 1'b1;
                        end
                        LDI: begin
                            ctrl.bus_src = BUS_IR;
                            ctrl.a_load  = 1'b1;
                        end
                        JMP: begin
                            ctrl.bus_src = BUS_IR;
                            ctrl.pc_load = 1'b1;
                        end
                        JC: begin
                            ctrl.bus_src = BUS_IR;
                            ctrl.pc_load = flags.carry;
                        end
                        JZ: begin
                            ctrl.bus_src = BUS_IR;
                            ctrl.pc_load = flags.zero;
                        end
                        OUT: begin
                            if (!out_pending) begin
                                ctrl.bus_src  = BUS_A;
                                ctrl.out_load = 1'b1;
                            end
                        end
                        default: ;  // NOP, HLT and unused codes
                    endcase
                end
                T3: begin
                    case (opcode)
                        LDA: begin
                            ctrl.bus_src = BUS_RAM;
                            ctrl.a_load  = 1'b1;
                        end
                        ADD, SUB: begin
                            ctrl.bus_src = BUS_RAM;  // Second operand into B
                            ctrl.b_load  = 1'b1;
                        end
                        STA: begin
                            ctrl.bus_src   = BUS_A;
                            ctrl.ram_write = 1'b1;
                        end
                        default: ;
                    endcase
                end
                T4: begin
                    if (opcode == ADD || opcode == SUB) begin
                        ctrl.bus_src   = BUS_ALU;
                        ctrl.a_load    = 1'b1;
                        ctrl.alu_sub   = (opcode == SUB);
                        ctrl.flag_load = 1'b1;
                    end
                end
                default: ;  // HALT drives nothing
            endcase
        end
    end

    assign halted = (step_q == HALT);

endmodule

`default_nettype wire

// ==== rtl/sap_alu.sv ====
`default_nettype none

module sap_alu (
    input  logic                clk,
    input  logic                rst,
    input  logic                core_hold,
    input  logic [7:0]          a,
    input  logic [7:0]          b,
    input  sap_pkg::ctrl_word_t ctrl,
    output logic [7:0]          result,
    output sap_pkg::alu_flags_t flags
);
    import sap_pkg::*;

    logic [data_w-1:0] b_op;  // B or its inverse
    logic [data_w:0]   sum;   // Carry in the top bit

    // Subtract as A + ~B + 1
    assign b_op   = ctrl.alu_sub ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, b_op} + {{data_w{1'b0}}, ctrl.alu_sub};
    assign result = sum[data_w-1:0];

    always_ff @(posedge clk) begin
        if (rst || core_hold) begin
            flags <= '0;
        end else if (ctrl.flag_load) begin
            flags.carry <= sum[data_w];          // No borrow on SUB
            flags.zero  <= (sum[data_w-1:0] == '0);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sap_datapath.sv ====
`default_nettype none

module sap_datapath (
    input  logic                clk,
    input  logic                rst,
    input  logic                core_hold,
    input  sap_pkg::ctrl_word_t ctrl,
    input  logic [7:0]          rd_data,
    output logic [3:0]          mar,
    output sap_pkg::mem_wr_t    core_wr,
    output sap_pkg::opcode_e    opcode,
    output sap_pkg::alu_flags_t flags,
    output logic [7:0]          out_data,
    output logic                out_valid,
    input  logic                out_ready
);
    import sap_pkg::*;

    logic [addr_w-1:0] pc_q;
    logic [data_w-1:0] ir_q;
    logic [data_w-1:0] a_q;
    logic [data_w-1:0] b_q;
    logic [data_w-1:0] alu_result;
    logic [data_w-1:0] bus;

    // Internal bus, one source at a time
    always_comb begin
        case (ctrl.bus_src)
            BUS_PC:  bus = {{(data_w-addr_w){1'b0}}, pc_q};
            BUS_RAM: bus = rd_data;
            BUS_IR:  bus = {{(data_w-addr_w){1'b0}}, ir_q[addr_w-1:0]};  // Operand only
            BUS_A:   bus = a_q;
            BUS_ALU: bus = alu_result;
            default: bus = '0;  // BUS_NONE
        endcase
    end

    // Program counter
    always_ff @(posedge clk) begin
        if (rst || core_hold) begin
            pc_q <= '0;  // Restart point
        end else if (ctrl.pc_load) begin
            pc_q <= bus[addr_w-1:0];
        end else if (ctrl.pc_inc) begin
            pc_q <= pc_q + 1'b1;  // Wraps 15 to 0
        end
    end

    // Memory address and instruction registers
    always_ff @(posedge clk) begin
        if (rst) begin
            mar  <= '0;
            ir_q <= '0;
        end else begin
            if (ctrl.mar_load) mar  <= bus[addr_w-1:0];
            if (ctrl.ir_load)  ir_q <= bus;
        end
    end

    // Accumulator and B operand register
    always_ff @(posedge clk) begin
        if (ctrl.a_load) a_q <= bus;
        if (ctrl.b_load) b_q <= bus;
    end

    // Output register with valid/ready
    always_ff @(posedge clk) begin
        if (rst || core_hold) begin
            out_data  <= '0;
            out_valid <= 1'b0;
        end else if (ctrl.out_load) begin
            out_data  <= bus;
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;  // Byte taken
        end
    end

    assign opcode = opcode_e'(ir_q[data_w-1:addr_w]);

    // STA write, data from the bus at the current MAR
    always_comb begin
        core_wr.en   = ctrl.ram_write;
        core_wr.addr = mar;
        core_wr.data = bus;
    end

    sap_alu u_alu (
        .clk       (clk),
        .rst       (rst),
        .core_hold (core_hold),
        .a         (a_q),
        .b         (b_q),
        .ctrl      (ctrl),
        .result    (alu_result),
        .flags     (flags)
    );

endmodule

`default_nettype wire

// ==== rtl/sap_ram.sv ====
`default_nettype none

module sap_ram (
    input  logic             clk,
    input  logic             rst,
    input  logic [3:0]       addr,
    output logic [7:0]       rd_data,
    input  sap_pkg::mem_wr_t core_wr,
    input  sap_pkg::mem_wr_t loader_wr
);
    import sap_pkg::*;

    logic [data_w-1:0] mem [mem_depth];  // Flip-flop storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < mem_depth; i++) begin
                mem[i] <= '0;  // All NOP
            end
        end else if (loader_wr.en) begin
            mem[loader_wr.addr] <= loader_wr.data;  // Loader has priority
        end else if (core_wr.en) begin
            mem[core_wr.addr] <= core_wr.data;
        end
    end

    assign rd_data = mem[addr];  // Asynchronous read

endmodule

`default_nettype wire

// ==== rtl/sap_cpu_top.sv ====
`default_nettype none

module sap_cpu_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       prog_mode,
    input  logic [7:0] prog_data,
    input  logic       prog_valid,
    output logic       prog_ready,
    output logic [7:0] out_data,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       halted
);
    import sap_pkg::*;

    mem_wr_t           loader_wr;   // Loader to memory
    mem_wr_t           core_wr;     // STA path
    logic              core_hold;   // Core in restart while loading
    ctrl_word_t        ctrl;
    opcode_e           opcode;
    alu_flags_t        flags;
    logic [addr_w-1:0] mar;
    logic [data_w-1:0] rd_data;

    sap_programmer u_programmer (
        .clk        (clk),
        .rst        (rst),
        .prog_mode  (prog_mode),
        .prog_data  (prog_data),
        .prog_valid (prog_valid),
        .prog_ready (prog_ready),
        .loader_wr  (loader_wr),
        .core_hold  (core_hold)
    );

    sap_control u_control (
        .clk         (clk),
        .rst         (rst),
        .core_hold   (core_hold),
        .opcode      (opcode),
        .flags       (flags),
        .out_pending (out_valid),  // Stalls OUT until taken
        .ctrl        (ctrl),
        .halted      (halted)
    );

    sap_datapath u_datapath (
        .clk       (clk),
        .rst       (rst),
        .core_hold (core_hold),
        .ctrl      (ctrl),
        .rd_data   (rd_data),
        .mar       (mar),
        .core_wr   (core_wr),
        .opcode    (opcode),
        .flags     (flags),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    sap_ram u_ram (
        .clk       (clk),
        .rst       (rst),
        .addr      (mar),
        .rd_data   (rd_data),
        .core_wr   (core_wr),
        .loader_wr (loader_wr)
    );

endmodule

`default_nettype wire

// ==== tests/sap_cpu_tb.sv ====
`default_nettype none

module sap_cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import sap_pkg::*;

    localparam int clk_period     = 40;
    localparam int rst_cycles     = 5;
    localparam int cycles_per_rec = 600;  // Watchdog budget per program
    localparam int halt_limit     = 400;  // Cycles a program may run before HLT
    localparam int drain_cycles   = 20;   // Quiet time after halt

    logic       clk;
    logic       rst;
    logic       prog_mode;
    logic [7:0] prog_data;
    logic       prog_valid;
    logic       prog_ready;
    logic [7:0] out_data;
    logic       out_valid;
    logic       out_ready;
    logic       halted;

    integer     seed = 90;
    logic [7:0] prog_bytes [$];   // Sixteen per record
    logic [7:0] exp_bytes [$];    // All expected OUT bytes back to back
    int         exp_first [$];    // Index of a record's first expected byte
    int         exp_count [$];
    int         num_records = 0;
    logic       stim_loaded = 1'b0;
    int         cur_prog = -1;    // Record under test, -1 before the first
    int         got_count = 0;    // Bytes taken so far for cur_prog

    sap_cpu_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .prog_mode  (prog_mode),
        .prog_data  (prog_data),
        .prog_valid (prog_valid),
        .prog_ready (prog_ready),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .halted     (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Watchdog sized from the number of records in the file
    initial begin
        wait (stim_loaded);
        repeat (rst_cycles + cycles_per_rec * num_records) @(posedge clk);
        $display("Run timed out after %0d cycles for %0d programs",
                 rst_cycles + cycles_per_rec * num_records, num_records);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic compare_byte(input logic [7:0] expected, input logic [7:0] actual);
        if (actual !== expected) begin
            $display("error: time %0t program %0d out_data expected %h got %h",
                     $time, cur_prog, expected, actual);
            $display("TB FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic compare_ready(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error: time %0t program %0d prog_ready expected %b got %b",
                     $time, cur_prog, expected, actual);
            $display("TB FAILED");
            $fatal(1, "ready mismatch");
        end
    endtask

    task automatic compare_halt(input logic actual);
        if (actual !== 1'b1) begin
            $display("error: time %0t program %0d halted expected 1 got %b",
                     $time, cur_prog, actual);
            $display("TB FAILED");
            $fatal(1, "halt dropped");
        end else if (got_count != exp_count[cur_prog]) begin
            $display("error: time %0t program %0d output count expected %0d got %0d",
                     $time, cur_prog, exp_count[cur_prog], got_count);
            $display("TB FAILED");
            $fatal(1, "output count");
        end
    endtask

    // Output monitor, both lines stable at the falling edge
    always @(negedge clk) begin
        if (out_valid && out_ready) begin  // Byte taken at the next rising edge
            if (cur_prog < 0 || got_count >= exp_count[cur_prog]) begin
                $display("Program %0d sent an extra byte %h at time %0t",
                         cur_prog, out_data, $time);
                $display("TB FAILED");
                $fatal(1, "extra output");
            end else begin
                compare_byte(exp_bytes[exp_first[cur_prog] + got_count], out_data);
                got_count++;
            end
        end
    end

    // Push one image through the loader with random idle gaps
    task automatic load_program(input int rec);
        int          i;
        logic [31:0] rnd;
        @(posedge clk);
        cur_prog   = rec;
        got_count  = 0;
        prog_mode  <= 1'b1;  // Core held, loader restarts at byte 0
        prog_valid <= 1'b0;
        @(negedge clk);
        compare_ready(1'b0, prog_ready);  // Mode not sampled yet
        @(negedge clk);
        compare_ready(1'b1, prog_ready);  // Ready one cycle after mode
        @(posedge clk);
        for (i = 0; i < mem_depth; i++) begin
            rnd = $random(seed);
            if (rnd[1:0] != 2'd0) begin
                prog_valid <= 1'b0;
                repeat (rnd[1:0]) @(posedge clk);  // 1 to 3 idle cycles
            end
            prog_valid <= 1'b1;
            prog_data  <= prog_bytes[rec * mem_depth + i];
            @(negedge clk);
            compare_ready(1'b1, prog_ready);  // Stays high through the window
            @(posedge clk);  // Accepted on this edge
        end
        prog_valid <= 1'b0;
        prog_mode  <= 1'b0;  // Run from address 0
    endtask

    // Run until HLT with random back-pressure, then check for quiet
    task automatic run_program(input int rec);
        int          cycles;
        logic        halt_seen;
        logic [31:0] rnd;
        cycles    = 0;
        halt_seen = 1'b0;
        while (!halt_seen && cycles < halt_limit) begin
            @(posedge clk);
            rnd = $random(seed);
            out_ready <= rnd[0];  // About half the cycles
            @(negedge clk);
            compare_ready(1'b0, prog_ready);  // Low while the core runs
            halt_seen = halted;
            cycles++;
        end
        if (!halt_seen) begin
            $display("Program %0d never reached HLT within %0d cycles", rec, halt_limit);
            $display("TB FAILED");
            $fatal(1, "missing halt");
        end
        repeat (drain_cycles) begin
            @(posedge clk);
            rnd = $random(seed);
            out_ready <= rnd[0];
        end
        @(negedge clk);
        compare_halt(halted);
    endtask

    initial begin
        int         fd;
        int         r;
        int         i;
        int         cnt;
        int         rec;
        logic [7:0] val;
        rst        = 1'b1;
        prog_mode  = 1'b0;
        prog_data  = 8'h00;
        prog_valid = 1'b0;
        out_ready  = 1'b0;

        fd = $fopen("tests/sap_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tests/sap_stim.txt");
            $display("TB FAILED");
            $fatal(1, "no stimulus");
        end
        r = $fscanf(fd, " %h", val);
        while (r == 1) begin  // Record is 16 bytes, a count, then expected bytes
            prog_bytes.push_back(val);
            for (i = 1; i < mem_depth; i++) begin
                r = $fscanf(fd, " %h", val);
                prog_bytes.push_back(val);
            end
            r = $fscanf(fd, " %h", cnt);
            exp_first.push_back(exp_bytes.size());
            exp_count.push_back(cnt);
            for (i = 0; i < cnt; i++) begin
                r = $fscanf(fd, " %h", val);
                exp_bytes.push_back(val);
            end
            num_records++;
            r = $fscanf(fd, " %h", val);
        end
        $fclose(fd);
        if (num_records == 0) begin
            $display("The stimulus file holds no program records");
            $display("TB FAILED");
            $fatal(1, "empty stimulus");
        end
        stim_loaded = 1'b1;

        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0;

        for (rec = 0; rec < num_records; rec++) begin
            load_program(rec);
            run_program(rec);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/sap_stim.txt ====
53 e0 57 e0 5f e0 f0 00 00 00 00 00 00 00 00 00
03 03 07 0f

1e 2f e0 76 51 e0 52 e0 3f e0 7d 54 e0 f0 f0 20
04 10 02 e2 04

1e 3e 85 5f e0 e0 7a 51 e0 f0 2f 8d e0 f0 35 0a
02 00 0a

5c 2f 4d 59 e0 1d e0 2e 4d 50 1d e0 f0 00 7f 81
03 09 8d 0c

5a e0 e0 55 e0 f0 5e e0 00 00 00 00 00 00 00 00
03 0a 0a 05

8c 1a 2a e0 3b 6f 00 00 00 00 c8 90 57 e0 f0 e0
03 90 00 07

// ==== sap_cpu.f ====
rtl/sap_pkg.sv
rtl/sap_programmer.sv
rtl/sap_control.sv
rtl/sap_alu.sv
rtl/sap_datapath.sv
rtl/sap_ram.sv
rtl/sap_cpu_top.sv
tests/sap_cpu_tb.sv

// ==== Bender.yml ====
package:
  name: sap_cpu

sources:
  - rtl/sap_pkg.sv
  - rtl/sap_programmer.sv
  - rtl/sap_control.sv
  - rtl/sap_alu.sv
  - rtl/sap_datapath.sv
  - rtl/sap_ram.sv
  - rtl/sap_cpu_top.sv
  - target: test
    files:
      - tests/sap_cpu_tb.sv
